// ==== common/tmu_pkg.sv ====
// texture unit shared definitions
`default_nettype none

package tmu_pkg;

	// request and pixel widths
	localparam int DADR_W  = 24;
	localparam int COLOR_W = 16;

	// 64x64 texture, six integer and six fractional coordinate bits
	localparam int TEX_LOG   = 6;
	localparam int TEX_ADR_W = 2 * TEX_LOG;
	localparam int FRAC_W    = 6;
	localparam int COORD_W   = TEX_LOG + FRAC_W;

	// bilinear weight peaks at 64*64 = 4096
	localparam int WEIGHT_W = 13;
	// weight times 5-bit and 6-bit channels
	localparam int RB_ACC_W = 17;
	localparam int G_ACC_W  = 18;

	// texel fetch sequence
	typedef enum logic [2:0] {
		FETCH_IDLE,
		FETCH_RD_A,
		FETCH_RD_B,
		FETCH_RD_C,
		FETCH_RD_D,
		FETCH_LAST,
		FETCH_OUT
	} fetch_state_t;

endpackage

`default_nettype wire

// ==== rtl/tmu_mult2.sv ====
// pipelined two-input multiplier
`timescale 1ns/1ps
`default_nettype none

module tmu_mult2 #(
	parameter int A_W = 7,
	parameter int B_W = 7,
	parameter int P_W = 13
) (
	input  logic           sys_clk,
	input  logic           ce_i,
	input  logic [A_W-1:0] a_i,
	input  logic [B_W-1:0] b_i,
	output logic [P_W-1:0] p_o
);

	logic [A_W-1:0] a_r;
	logic [B_W-1:0] b_r;
	logic [P_W-1:0] p_r;

	// operand stage
	always_ff @(posedge sys_clk) begin
		if (ce_i) begin
			a_r <= a_i;
			b_r <= b_i;
		end
	end

	// product stage, kept modulo 2^P_W
	always_ff @(posedge sys_clk) begin
		if (ce_i) begin
			p_r <= P_W'(a_r) * P_W'(b_r);
		end
	end

	assign p_o = p_r;

endmodule

`default_nettype wire

// ==== rtl/tmu_texmem.sv ====
// texture memory
`timescale 1ns/1ps
`default_nettype none

module tmu_texmem (
	input  logic                          sys_clk,
	input  logic                          rd_en_i,
	input  logic [tmu_pkg::TEX_ADR_W-1:0] rd_adr_i,
	output logic [tmu_pkg::COLOR_W-1:0]   rd_dat_o,
	input  logic                          we_i,
	input  logic [tmu_pkg::TEX_ADR_W-1:0] wr_adr_i,
	input  logic [tmu_pkg::COLOR_W-1:0]   wr_dat_i
);

	import tmu_pkg::*;

	// one RGB565 word per texel, y*64+x
	logic [COLOR_W-1:0] mem [1 << TEX_ADR_W];
	logic [COLOR_W-1:0] rd_dat_r;

	// load port
	always_ff @(posedge sys_clk) begin
		if (we_i) begin
			mem[wr_adr_i] <= wr_dat_i;
		end
	end

	// registered read, data one cycle after the address
	always_ff @(posedge sys_clk) begin
		if (rd_en_i) begin
			rd_dat_r <= mem[rd_adr_i];
		end
	end

	assign rd_dat_o = rd_dat_r;

	// loader must stay off while the fetch stage is reading
	a_no_wr_during_rd: assert property (
		@(posedge sys_clk) !(we_i && rd_en_i)
	) else $error("texture write collided with a fetch read");

endmodule

`default_nettype wire

// ==== fetch/tmu_texel_fetch.sv ====
// texel fetch stage
`timescale 1ns/1ps
`default_nettype none

module tmu_texel_fetch (
	input  logic                          sys_clk,
	input  logic                          sys_rst,
	output logic                          busy_o,

	input  logic                          pipe_stb_i,
	output logic                          pipe_ack_o,
	input  logic [tmu_pkg::COORD_W-1:0]   u_i,
	input  logic [tmu_pkg::COORD_W-1:0]   v_i,
	input  logic [tmu_pkg::DADR_W-1:0]    dadr_i,

	output logic                          rd_en_o,
	output logic [tmu_pkg::TEX_ADR_W-1:0] rd_adr_o,
	input  logic [tmu_pkg::COLOR_W-1:0]   rd_dat_i,

	output logic                          pipe_stb_o,
	input  logic                          pipe_ack_i,
	output logic [tmu_pkg::DADR_W-1:0]    dadr_o,
	output logic [tmu_pkg::COLOR_W-1:0]   colora_o,
	output logic [tmu_pkg::COLOR_W-1:0]   colorb_o,
	output logic [tmu_pkg::COLOR_W-1:0]   colorc_o,
	output logic [tmu_pkg::COLOR_W-1:0]   colord_o,
	output logic [tmu_pkg::FRAC_W-1:0]    x_frac_o,
	output logic [tmu_pkg::FRAC_W-1:0]    y_frac_o
);

	import tmu_pkg::*;

	fetch_state_t state;
	fetch_state_t state_next;

	logic               accept;
	logic [COORD_W-1:0] u_r;
	logic [COORD_W-1:0] v_r;
	logic [DADR_W-1:0]  dadr_r;
	logic [COLOR_W-1:0] colora_r;
	logic [COLOR_W-1:0] colorb_r;
	logic [COLOR_W-1:0] colorc_r;
	logic [COLOR_W-1:0] colord_r;

	// integer texel position and its wrapped neighbours
	logic [TEX_LOG-1:0] x0;
	logic [TEX_LOG-1:0] y0;
	logic [TEX_LOG-1:0] x1;
	logic [TEX_LOG-1:0] y1;

	assign accept = pipe_stb_i && pipe_ack_o;

	assign x0 = u_r[COORD_W-1:FRAC_W];
	assign y0 = v_r[COORD_W-1:FRAC_W];
	// 6-bit add wraps 63 back to 0
	assign x1 = x0 + TEX_LOG'(1);
	assign y1 = y0 + TEX_LOG'(1);

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= FETCH_IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			FETCH_IDLE: if (accept) state_next = FETCH_RD_A;
			FETCH_RD_A: state_next = FETCH_RD_B;
			FETCH_RD_B: state_next = FETCH_RD_C;
			FETCH_RD_C: state_next = FETCH_RD_D;
			FETCH_RD_D: state_next = FETCH_LAST;
			FETCH_LAST: state_next = FETCH_OUT;
			FETCH_OUT:  if (pipe_ack_i) state_next = FETCH_IDLE;
			default:    state_next = FETCH_IDLE;
		endcase
	end

	// one read per cycle, a b c d order
	always_comb begin
		rd_en_o  = 1'b0;
		rd_adr_o = {y0, x0};
		case (state)
			FETCH_RD_A: begin
				rd_en_o  = 1'b1;
				rd_adr_o = {y0, x0};
			end
			FETCH_RD_B: begin
				rd_en_o  = 1'b1;
				rd_adr_o = {y0, x1};
			end
			FETCH_RD_C: begin
				rd_en_o  = 1'b1;
				rd_adr_o = {y1, x0};
			end
			FETCH_RD_D: begin
				rd_en_o  = 1'b1;
				rd_adr_o = {y1, x1};
			end
			default: begin
				rd_en_o  = 1'b0;
			end
		endcase
	end

	// request latch and texel capture, data lags the address by one cycle
	always_ff @(posedge sys_clk) begin
		if (accept) begin
			u_r    <= u_i;
			v_r    <= v_i;
			dadr_r <= dadr_i;
		end
		case (state)
			FETCH_RD_B: colora_r <= rd_dat_i;
			FETCH_RD_C: colorb_r <= rd_dat_i;
			FETCH_RD_D: colorc_r <= rd_dat_i;
			FETCH_LAST: colord_r <= rd_dat_i;
			default: ;
		endcase
	end

	assign pipe_ack_o = (state == FETCH_IDLE);
	assign busy_o     = (state != FETCH_IDLE);
	assign pipe_stb_o = (state == FETCH_OUT);

	assign dadr_o   = dadr_r;
	assign colora_o = colora_r;
	assign colorb_o = colorb_r;
	assign colorc_o = colorc_r;
	assign colord_o = colord_r;
	assign x_frac_o = u_r[FRAC_W-1:0];
	assign y_frac_o = v_r[FRAC_W-1:0];

	// offered item holds until the blend takes it
	a_out_hold: assert property (
		@(posedge sys_clk) disable iff (sys_rst)
		pipe_stb_o && !pipe_ack_i |=> pipe_stb_o && $stable({dadr_o, colora_o,
			colorb_o, colorc_o, colord_o, x_frac_o, y_frac_o})
	) else $error("fetch output changed before acknowledge");

endmodule

`default_nettype wire

// ==== blend/tmu_blend.sv ====
// bilinear blend pipeline
`timescale 1ns/1ps
`default_nettype none

module tmu_blend (
	input  logic                        sys_clk,
	input  logic                        sys_rst,
	output logic                        busy_o,

	input  logic                        pipe_stb_i,
	output logic                        pipe_ack_o,
	input  logic [tmu_pkg::DADR_W-1:0]  dadr_i,
	input  logic [tmu_pkg::COLOR_W-1:0] colora_i,
	input  logic [tmu_pkg::COLOR_W-1:0] colorb_i,
	input  logic [tmu_pkg::COLOR_W-1:0] colorc_i,
	input  logic [tmu_pkg::COLOR_W-1:0] colord_i,
	input  logic [tmu_pkg::FRAC_W-1:0]  x_frac_i,
	input  logic [tmu_pkg::FRAC_W-1:0]  y_frac_i,

	output logic                        pipe_stb_o,
	input  logic                        pipe_ack_i,
	output logic [tmu_pkg::DADR_W-1:0]  dadr_o,
	output logic [tmu_pkg::COLOR_W-1:0] color_o
);

	import tmu_pkg::*;

	// one enable for every stage and every multiplier
	logic pipe_en;

	// valid bit and address per stage
	logic [5:1]        valid;
	logic [DADR_W-1:0] dadr_q [1:5];

	// texels a b c d, carried until the weights are ready
	logic [COLOR_W-1:0] color_1 [4];
	logic [COLOR_W-1:0] color_2 [4];

	// weight operands, seven bits so that 64 fits
	logic [FRAC_W:0] xf;
	logic [FRAC_W:0] yf;
	logic [FRAC_W:0] xf_inv;
	logic [FRAC_W:0] yf_inv;
	logic [FRAC_W:0] wx [4];
	logic [FRAC_W:0] wy [4];

	logic [WEIGHT_W-1:0] w_2 [4];

	// weighted channel terms
	logic [RB_ACC_W-1:0] r_4 [4];
	logic [G_ACC_W-1:0]  g_4 [4];
	logic [RB_ACC_W-1:0] b_4 [4];

	// channel sums, scaled by 4096
	logic [RB_ACC_W-1:0] r_5;
	logic [G_ACC_W-1:0]  g_5;
	logic [RB_ACC_W-1:0] b_5;

	assign pipe_en = !valid[5] || pipe_ack_i;

	assign xf     = {1'b0, x_frac_i};
	assign yf     = {1'b0, y_frac_i};
	assign xf_inv = 7'd64 - xf;
	assign yf_inv = 7'd64 - yf;

	// pa pb pc pd operand pairs
	assign wx[0] = xf_inv;
	assign wy[0] = yf_inv;
	assign wx[1] = xf;
	assign wy[1] = yf_inv;
	assign wx[2] = xf_inv;
	assign wy[2] = yf;
	assign wx[3] = xf;
	assign wy[3] = yf;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			valid <= '0;
		end else if (pipe_en) begin
			valid <= {valid[4:1], pipe_stb_i};
		end
	end

	always_ff @(posedge sys_clk) begin
		if (pipe_en) begin
			dadr_q[1] <= dadr_i;
			for (int s = 2; s <= 5; s++) begin
				dadr_q[s] <= dadr_q[s-1];
			end

			color_1[0] <= colora_i;
			color_1[1] <= colorb_i;
			color_1[2] <= colorc_i;
			color_1[3] <= colord_i;
			color_2    <= color_1;

			// weights sum to 4096, so the sums never overflow
			r_5 <= r_4[0] + r_4[1] + r_4[2] + r_4[3];
			g_5 <= g_4[0] + g_4[1] + g_4[2] + g_4[3];
			b_5 <= b_4[0] + b_4[1] + b_4[2] + b_4[3];
		end
	end

	for (genvar i = 0; i < 4; i++) begin : g_texel
		// weight ready in stage two
		tmu_mult2 #(
			.A_W(FRAC_W + 1),
			.B_W(FRAC_W + 1),
			.P_W(WEIGHT_W)
		) u_weight (
			.sys_clk(sys_clk),
			.ce_i   (pipe_en),
			.a_i    (wx[i]),
			.b_i    (wy[i]),
			.p_o    (w_2[i])
		);

		// channel terms ready in stage four, RGB565 split here
		tmu_mult2 #(
			.A_W(WEIGHT_W),
			.B_W(6),
			.P_W(RB_ACC_W)
		) u_red (
			.sys_clk(sys_clk),
			.ce_i   (pipe_en),
			.a_i    (w_2[i]),
			.b_i    ({1'b0, color_2[i][15:11]}),
			.p_o    (r_4[i])
		);

		tmu_mult2 #(
			.A_W(WEIGHT_W),
			.B_W(6),
			.P_W(G_ACC_W)
		) u_green (
			.sys_clk(sys_clk),
			.ce_i   (pipe_en),
			.a_i    (w_2[i]),
			.b_i    (color_2[i][10:5]),
			.p_o    (g_4[i])
		);

		tmu_mult2 #(
			.A_W(WEIGHT_W),
			.B_W(6),
			.P_W(RB_ACC_W)
		) u_blue (
			.sys_clk(sys_clk),
			.ce_i   (pipe_en),
			.a_i    (w_2[i]),
			.b_i    ({1'b0, color_2[i][4:0]}),
			.p_o    (b_4[i])
		);
	end

	assign pipe_stb_o = valid[5];
	assign pipe_ack_o = pipe_en;
	assign dadr_o     = dadr_q[5];
	// drop the 12 fraction bits of each sum
	assign color_o    = {r_5[16:12], g_5[17:12], b_5[16:12]};
	assign busy_o     = |valid;

	a_stb_hold: assert property (
		@(posedge sys_clk) disable iff (sys_rst)
		pipe_stb_o && !pipe_ack_i |=> pipe_stb_o
	) else $error("blend output dropped without acknowledge");

endmodule

`default_nettype wire

// ==== rtl/tmu_top.sv ====
// texture mapping unit top
`timescale 1ns/1ps
`default_nettype none

module tmu_top (
	input  logic                          sys_clk,
	input  logic                          sys_rst,

	input  logic                          tex_we_i,
	input  logic [tmu_pkg::TEX_ADR_W-1:0] tex_adr_i,
	input  logic [tmu_pkg::COLOR_W-1:0]   tex_dat_i,

	input  logic                          pipe_stb_i,
	output logic                          pipe_ack_o,
	input  logic [tmu_pkg::COORD_W-1:0]   u_i,
	input  logic [tmu_pkg::COORD_W-1:0]   v_i,
	input  logic [tmu_pkg::DADR_W-1:0]    dadr_i,

	output logic                          pipe_stb_o,
	input  logic                          pipe_ack_i,
	output logic [tmu_pkg::DADR_W-1:0]    dadr_o,
	output logic [tmu_pkg::COLOR_W-1:0]   color_o,
	output logic                          busy_o
);

	import tmu_pkg::*;

	logic                 rd_en;
	logic [TEX_ADR_W-1:0] rd_adr;
	logic [COLOR_W-1:0]   rd_dat;

	// fetch to blend
	logic               f_stb;
	logic               f_ack;
	logic [DADR_W-1:0]  f_dadr;
	logic [COLOR_W-1:0] f_colora;
	logic [COLOR_W-1:0] f_colorb;
	logic [COLOR_W-1:0] f_colorc;
	logic [COLOR_W-1:0] f_colord;
	logic [FRAC_W-1:0]  f_x_frac;
	logic [FRAC_W-1:0]  f_y_frac;

	logic fetch_busy;
	logic blend_busy;

	tmu_texmem u_texmem (
		.sys_clk (sys_clk),
		.rd_en_i (rd_en),
		.rd_adr_i(rd_adr),
		.rd_dat_o(rd_dat),
		.we_i    (tex_we_i),
		.wr_adr_i(tex_adr_i),
		.wr_dat_i(tex_dat_i)
	);

	tmu_texel_fetch u_fetch (
		.sys_clk   (sys_clk),
		.sys_rst   (sys_rst),
		.busy_o    (fetch_busy),
		.pipe_stb_i(pipe_stb_i),
		.pipe_ack_o(pipe_ack_o),
		.u_i       (u_i),
		.v_i       (v_i),
		.dadr_i    (dadr_i),
		.rd_en_o   (rd_en),
		.rd_adr_o  (rd_adr),
		.rd_dat_i  (rd_dat),
		.pipe_stb_o(f_stb),
		.pipe_ack_i(f_ack),
		.dadr_o    (f_dadr),
		.colora_o  (f_colora),
		.colorb_o  (f_colorb),
		.colorc_o  (f_colorc),
		.colord_o  (f_colord),
		.x_frac_o  (f_x_frac),
		.y_frac_o  (f_y_frac)
	);

	tmu_blend u_blend (
		.sys_clk   (sys_clk),
		.sys_rst   (sys_rst),
		.busy_o    (blend_busy),
		.pipe_stb_i(f_stb),
		.pipe_ack_o(f_ack),
		.dadr_i    (f_dadr),
		.colora_i  (f_colora),
		.colorb_i  (f_colorb),
		.colorc_i  (f_colorc),
		.colord_i  (f_colord),
		.x_frac_i  (f_x_frac),
		.y_frac_i  (f_y_frac),
		.pipe_stb_o(pipe_stb_o),
		.pipe_ack_i(pipe_ack_i),
		.dadr_o    (dadr_o),
		.color_o   (color_o)
	);

	assign busy_o = fetch_busy || blend_busy;

endmodule

`default_nettype wire

// ==== verification/tb_tmu.sv ====
// texture unit testbench
`timescale 1ns/1ps
`default_nettype none

module tb_tmu;

	import tmu_pkg::*;

	localparam logic [31:0] SEED = 32'h368844dc;
	localparam int TEX_WORDS    = 1 << TEX_ADR_W;
	localparam int RESET_CYCLES = 16;
	localparam int N_RANDOM     = 200;
	localparam int N_WRAP       = 96;
	localparam int N_GAPPED     = 300;
	localparam int N_REQUESTS   = TEX_WORDS + N_RANDOM + N_WRAP + N_GAPPED;
	// forty cycles per request on top of reset and texture load
	localparam int WATCHDOG_CYCLES = N_REQUESTS * 40 + TEX_WORDS + RESET_CYCLES;

	logic                 sys_clk;
	logic                 sys_rst;
	logic                 tex_we_i;
	logic [TEX_ADR_W-1:0] tex_adr_i;
	logic [COLOR_W-1:0]   tex_dat_i;
	logic                 pipe_stb_i;
	logic                 pipe_ack_o;
	logic [COORD_W-1:0]   u_i;
	logic [COORD_W-1:0]   v_i;
	logic [DADR_W-1:0]    dadr_i;
	logic                 pipe_stb_o;
	logic                 pipe_ack_i;
	logic [DADR_W-1:0]    dadr_o;
	logic [COLOR_W-1:0]   color_o;
	logic                 busy_o;

	// texture copy and expected pixels in request order
	logic [COLOR_W-1:0] tex [TEX_WORDS];
	logic [DADR_W-1:0]  exp_dadr_q [$];
	logic [COLOR_W-1:0] exp_color_q [$];

	logic [31:0] stim_state;
	logic [31:0] bp_state;
	logic        bp_on;
	int          errors;
	int          checks;
	int          tests;
	int          sent;
	int          delivered;

	tmu_top u_tmu_top (
		.sys_clk   (sys_clk),
		.sys_rst   (sys_rst),
		.tex_we_i  (tex_we_i),
		.tex_adr_i (tex_adr_i),
		.tex_dat_i (tex_dat_i),
		.pipe_stb_i(pipe_stb_i),
		.pipe_ack_o(pipe_ack_o),
		.u_i       (u_i),
		.v_i       (v_i),
		.dadr_i    (dadr_i),
		.pipe_stb_o(pipe_stb_o),
		.pipe_ack_i(pipe_ack_i),
		.dadr_o    (dadr_o),
		.color_o   (color_o),
		.busy_o    (busy_o)
	);

	initial sys_clk = 1'b0;
	always #4 sys_clk = ~sys_clk;

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] next_stim();
		stim_state = lcg_step(stim_state);
		return stim_state;
	endfunction

	// texel address y*64+x with both indices wrapped
	function automatic logic [TEX_ADR_W-1:0] tex_index(input int x, input int y);
		return TEX_ADR_W'((y % 64) * 64 + (x % 64));
	endfunction

	// bilinear reference, floor of the weighted sum over 4096
	function automatic logic [COLOR_W-1:0] blend_model(input logic [COORD_W-1:0] u,
		input logic [COORD_W-1:0] v);
		int xi;
		int yi;
		int xf;
		int yf;
		int k;
		int r;
		int g;
		int b;
		int w [4];
		logic [COLOR_W-1:0] t [4];
		logic [4:0] rq;
		logic [5:0] gq;
		logic [4:0] bq;
		xi = int'(u[COORD_W-1:FRAC_W]);
		yi = int'(v[COORD_W-1:FRAC_W]);
		xf = int'(u[FRAC_W-1:0]);
		yf = int'(v[FRAC_W-1:0]);
		t[0] = tex[tex_index(xi, yi)];
		t[1] = tex[tex_index(xi + 1, yi)];
		t[2] = tex[tex_index(xi, yi + 1)];
		t[3] = tex[tex_index(xi + 1, yi + 1)];
		w[0] = (64 - xf) * (64 - yf);
		w[1] = xf * (64 - yf);
		w[2] = (64 - xf) * yf;
		w[3] = xf * yf;
		r = 0;
		g = 0;
		b = 0;
		for (k = 0; k < 4; k++) begin
			r += w[k] * int'(t[k][15:11]);
			g += w[k] * int'(t[k][10:5]);
			b += w[k] * int'(t[k][4:0]);
		end
		rq = 5'(r / 4096);
		gq = 6'(g / 4096);
		bq = 5'(b / 4096);
		return {rq, gq, bq};
	endfunction

	// random stalls on the pixel port, roughly one cycle in four
	always @(negedge sys_clk) begin
		if (bp_on) begin
			bp_state = lcg_step(bp_state);
			pipe_ack_i = (bp_state[31:30] != 2'b00);
		end else begin
			pipe_ack_i = 1'b1;
		end
	end

	always @(posedge sys_clk) begin : pixel_monitor
		logic [DADR_W-1:0]  want_dadr;
		logic [COLOR_W-1:0] want_color;
		if (!sys_rst && pipe_stb_o && pipe_ack_i) begin
			delivered++;
			if (exp_color_q.size() == 0) begin
				$display("%0t: pixel port delivered an item that no request asked for", $time);
				errors++;
			end else begin
				want_dadr  = exp_dadr_q.pop_front();
				want_color = exp_color_q.pop_front();
				checks++;
				assert (dadr_o == want_dadr) else begin
					$display("Fail %0t dadr_o expected %h got %h", $time, want_dadr, dadr_o);
					errors++;
				end
				assert (color_o == want_color) else begin
					$display("Fail %0t color_o expected %h got %h", $time, want_color, color_o);
					errors++;
				end
			end
		end
	end

	task automatic check_flag(input string name, input logic got, input logic want);
		checks++;
		assert (got === want) else begin
			$display("Fail %0t %s expected %b got %b", $time, name, want, got);
			errors++;
		end
	endtask

	// call on a falling edge, returns on the falling edge after acceptance
	task automatic send_request(input logic [COORD_W-1:0] u, input logic [COORD_W-1:0] v);
		logic [31:0] r;
		r = next_stim();
		pipe_stb_i = 1'b1;
		u_i        = u;
		v_i        = v;
		dadr_i     = r[31:8];
		@(posedge sys_clk);
		while (!pipe_ack_o) @(posedge sys_clk);
		exp_dadr_q.push_back(dadr_i);
		exp_color_q.push_back(blend_model(u, v));
		sent++;
		@(negedge sys_clk);
		pipe_stb_i = 1'b0;
	endtask

	task automatic drain(input string name);
		@(negedge sys_clk);
		while (busy_o || pipe_stb_o) @(negedge sys_clk);
		repeat (2) @(negedge sys_clk);
		if (exp_color_q.size() != 0) begin
			$display("%0d expected pixels of %s never came out", exp_color_q.size(), name);
			errors++;
			exp_color_q.delete();
			exp_dadr_q.delete();
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests++;
		if (errors == errors_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errors - errors_before);
		end
	endtask

	// idle flags, random load, then every texel read back with zero fractions
	task automatic test_readback();
		int e0;
		int i;
		logic [31:0] r;
		e0 = errors;
		check_flag("pipe_stb_o", pipe_stb_o, 1'b0);
		check_flag("busy_o", busy_o, 1'b0);
		check_flag("pipe_ack_o", pipe_ack_o, 1'b1);
		for (i = 0; i < TEX_WORDS; i++) begin
			r = next_stim();
			tex[TEX_ADR_W'(i)] = r[31:16];
			tex_we_i  = 1'b1;
			tex_adr_i = TEX_ADR_W'(i);
			tex_dat_i = r[31:16];
			@(negedge sys_clk);
		end
		tex_we_i = 1'b0;
		for (i = 0; i < TEX_WORDS; i++) begin
			send_request({TEX_LOG'(i % 64), FRAC_W'(0)}, {TEX_LOG'(i / 64), FRAC_W'(0)});
		end
		drain("readback");
		report_test("readback", e0);
	endtask

	task automatic test_random();
		int e0;
		int i;
		logic [31:0] r;
		e0 = errors;
		for (i = 0; i < N_RANDOM; i++) begin
			r = next_stim();
			send_request(r[31:20], r[19:8]);
		end
		drain("random blend");
		report_test("random blend", e0);
	endtask

	// integer part 63 in u, in v, then in both
	task automatic test_wrap();
		int e0;
		int i;
		logic [31:0] r;
		logic [TEX_LOG-1:0] xi;
		logic [TEX_LOG-1:0] yi;
		e0 = errors;
		for (i = 0; i < N_WRAP; i++) begin
			r  = next_stim();
			xi = r[31:26];
			yi = r[25:20];
			if (i % 3 != 1) xi = 6'd63;
			if (i % 3 != 0) yi = 6'd63;
			send_request({xi, r[19:14]}, {yi, r[13:8]});
		end
		drain("edge wrap");
		report_test("edge wrap", e0);
	endtask

	task automatic test_gapped();
		int e0;
		int i;
		logic [31:0] r;
		e0 = errors;
		bp_on = 1'b1;
		for (i = 0; i < N_GAPPED; i++) begin
			r = next_stim();
			send_request(r[31:20], r[19:8]);
			r = next_stim();
			repeat (int'(r[31:29])) @(negedge sys_clk);
		end
		drain("gaps and stalls");
		bp_on = 1'b0;
		report_test("gaps and stalls", e0);
	endtask

	task automatic test_idle_end();
		int e0;
		e0 = errors;
		check_flag("busy_o", busy_o, 1'b0);
		check_flag("pipe_stb_o", pipe_stb_o, 1'b0);
		if (exp_color_q.size() != 0) begin
			$display("%0d expected pixels are still queued at the end", exp_color_q.size());
			errors++;
		end
		if (delivered != sent) begin
			$display("%0d requests were accepted but %0d pixels came out", sent, delivered);
			errors++;
		end
		report_test("idle at end", e0);
	endtask

	initial begin
		stim_state = SEED;
		bp_state   = ~SEED;
		bp_on      = 1'b0;
		errors     = 0;
		checks     = 0;
		tests      = 0;
		sent       = 0;
		delivered  = 0;
		sys_rst    = 1'b1;
		tex_we_i   = 1'b0;
		tex_adr_i  = '0;
		tex_dat_i  = '0;
		pipe_stb_i = 1'b0;
		u_i        = '0;
		v_i        = '0;
		dadr_i     = '0;
		pipe_ack_i = 1'b1;
		repeat (RESET_CYCLES) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst = 1'b0;
		@(negedge sys_clk);
		test_readback();
		test_random();
		test_wrap();
		test_gapped();
		test_idle_end();
		$display("tests %0d, requests %0d, checks %0d, errors %0d", tests, sent, checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
		$display("watchdog expired after %0d cycles, the pipeline stopped making progress",
			WATCHDOG_CYCLES);
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
common/tmu_pkg.sv
rtl/tmu_mult2.sv
rtl/tmu_texmem.sv
fetch/tmu_texel_fetch.sv
blend/tmu_blend.sv
rtl/tmu_top.sv
verification/tb_tmu.sv

// ==== Makefile ====
# Verilator build and run for the texture unit testbench

VERILATOR ?= verilator
TOP       ?= tb_tmu
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_MSG  ?= Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "run ok" || \
		(echo "run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
